/* include/chip8_consts.svh */
// chip8 core constants
// address width, reset vector, register and stack sizes

`ifndef CHIP8_CONSTS_SVH
`define CHIP8_CONSTS_SVH

// 4 KiB address space
`define CHIP8_ADDR_W 12

// programs are loaded at 0x200
`define CHIP8_RESET_PC 12'h200

// V0 to VF
`define CHIP8_NUM_REGS 16

`define CHIP8_STACK_DEPTH 16

// VF doubles as the carry, borrow and shift flag
`define CHIP8_FLAG_REG 15

`endif

/* logic/chip8_pkg.sv */
// chip8 shared types
// data widths, fsm states and the control bundles between the core blocks

`include "chip8_consts.svh"

package chip8_pkg;

  typedef logic [`CHIP8_ADDR_W-1:0] addr_t;
  typedef logic [7:0] byte_t;
  typedef logic [15:0] opcode_t;
  typedef logic [$clog2(`CHIP8_NUM_REGS)-1:0] reg_idx_t;

  typedef enum logic [2:0] {
    FETCH_HI,
    FETCH_LO,
    CAPTURE_LO,
    EXECUTE,
    STORE_BURST
  } cpu_state_t;

  // register file operations, including the four skip compares
  typedef enum logic [3:0] {
    ALU_NONE,
    ALU_LD_IMM,
    ALU_ADD_IMM,
    ALU_MOV,
    ALU_OR,
    ALU_AND,
    ALU_XOR,
    ALU_ADD,
    ALU_SUB,
    ALU_SHR,
    ALU_SUBN,
    ALU_SHL,
    ALU_SE_IMM,
    ALU_SNE_IMM,
    ALU_SE_REG,
    ALU_SNE_REG
  } alu_op_t;

  typedef enum logic [2:0] {
    PC_NEXT,
    PC_SKIP,
    PC_JUMP,
    PC_JUMP_V0,
    PC_CALL,
    PC_RET,
    PC_HOLD
  } pc_op_t;

  typedef enum logic [1:0] {
    ADDR_PC,
    ADDR_PC_PLUS1,
    ADDR_I_COUNT
  } addr_sel_t;

  typedef struct packed {
    alu_op_t  alu_op;
    pc_op_t   pc_op;
    reg_idx_t vx;
    reg_idx_t vy;
    byte_t    nn;
    addr_t    nnn;
    logic     i_load;
    logic     i_add;
    logic     bcd_mode;
    logic     strobe;
  } exec_ctl_t;

  typedef struct packed {
    logic  read;
    logic  write;
    addr_t addr;
    byte_t wdata;
  } mem_req_t;

endpackage

/* logic/chip8_burst_counter.sv */
// store burst counter
// steps the beat index of a memory write burst and flags its last beat

`timescale 1ns/1ps

module chip8_burst_counter (
  input  logic                clk,
  input  logic                reset,
  input  logic                start,
  input  chip8_pkg::reg_idx_t limit,
  input  logic                advance,
  output chip8_pkg::reg_idx_t count,
  output logic                last
);
  import chip8_pkg::*;

  reg_idx_t limit_q;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      count   <= '0;
      limit_q <= '0;
    end else if (start) begin
      count   <= '0;
      limit_q <= limit;
    end else if (advance) begin
      count <= count + 1'b1;
    end
  end

  assign last = (count == limit_q);

endmodule

/* logic/chip8_regfile_alu.sv */
// chip8 register file and alu
// holds V0-VF, runs the 8XY group, evaluates skips and picks store data

`timescale 1ns/1ps

`include "chip8_consts.svh"

module chip8_regfile_alu (
  input  logic                 clk,
  input  logic                 reset,
  input  chip8_pkg::exec_ctl_t exec_ctl,
  input  chip8_pkg::reg_idx_t  count,
  output logic                 skip_taken,
  output chip8_pkg::byte_t     v0,
  output chip8_pkg::byte_t     vx_value,
  output chip8_pkg::byte_t     wdata
);
  import chip8_pkg::*;

  byte_t      v_regs [`CHIP8_NUM_REGS];
  byte_t      vx_val;
  byte_t      vy_val;
  byte_t      result;
  byte_t      hundreds;
  byte_t      tens;
  byte_t      units;
  logic [8:0] sum;
  logic       flag;
  logic       write_x;
  logic       write_f;

  assign vx_val = v_regs[exec_ctl.vx];
  assign vy_val = v_regs[exec_ctl.vy];
  assign sum    = {1'b0, vx_val} + {1'b0, vy_val};

  always_comb begin
    result  = vx_val;
    flag    = 1'b0;
    write_x = 1'b0;
    write_f = 1'b0;
    case (exec_ctl.alu_op)
      ALU_LD_IMM: begin
        result  = exec_ctl.nn;
        write_x = 1'b1;
      end
      // no carry out for 7XNN
      ALU_ADD_IMM: begin
        result  = vx_val + exec_ctl.nn;
        write_x = 1'b1;
      end
      ALU_MOV: begin
        result  = vy_val;
        write_x = 1'b1;
      end
      ALU_OR: begin
        result  = vx_val | vy_val;
        write_x = 1'b1;
      end
      ALU_AND: begin
        result  = vx_val & vy_val;
        write_x = 1'b1;
      end
      ALU_XOR: begin
        result  = vx_val ^ vy_val;
        write_x = 1'b1;
      end
      ALU_ADD: begin
        result  = sum[7:0];
        flag    = sum[8];
        write_x = 1'b1;
        write_f = 1'b1;
      end
      ALU_SUB: begin
        result  = vx_val - vy_val;
        flag    = (vx_val >= vy_val);
        write_x = 1'b1;
        write_f = 1'b1;
      end
      ALU_SHR: begin
        result  = vx_val >> 1;
        flag    = vx_val[0];
        write_x = 1'b1;
        write_f = 1'b1;
      end
      ALU_SUBN: begin
        result  = vy_val - vx_val;
        flag    = (vy_val > vx_val);
        write_x = 1'b1;
        write_f = 1'b1;
      end
      ALU_SHL: begin
        result  = vx_val << 1;
        flag    = vx_val[7];
        write_x = 1'b1;
        write_f = 1'b1;
      end
      default: write_x = 1'b0;
    endcase
  end

  always_comb begin
    case (exec_ctl.alu_op)
      ALU_SE_IMM:  skip_taken = (vx_val == exec_ctl.nn);
      ALU_SNE_IMM: skip_taken = (vx_val != exec_ctl.nn);
      ALU_SE_REG:  skip_taken = (vx_val == vy_val);
      ALU_SNE_REG: skip_taken = (vx_val != vy_val);
      default:     skip_taken = 1'b0;
    endcase
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      for (int i = 0; i < `CHIP8_NUM_REGS; i++)
        v_regs[i] <= '0;
    end else if (exec_ctl.strobe) begin
      if (write_x)
        v_regs[exec_ctl.vx] <= result;
      // flag written second so it wins when X is F
      if (write_f)
        v_regs[`CHIP8_FLAG_REG] <= {7'd0, flag};
    end
  end

  assign hundreds = vx_val / 8'd100;
  assign tens     = (vx_val / 8'd10) % 8'd10;
  assign units    = vx_val % 8'd10;

  // bcd beats go hundreds, tens, units
  always_comb begin
    if (exec_ctl.bcd_mode) begin
      case (count)
        4'd0:    wdata = hundreds;
        4'd1:    wdata = tens;
        default: wdata = units;
      endcase
    end else begin
      wdata = v_regs[count];
    end
  end

  assign v0       = v_regs[0];
  assign vx_value = vx_val;

endmodule

/* logic/chip8_addr_unit.sv */
// chip8 address unit
// pc, index register, call stack and memory address select

`timescale 1ns/1ps

`include "chip8_consts.svh"

module chip8_addr_unit (
  input  logic                 clk,
  input  logic                 reset,
  input  chip8_pkg::exec_ctl_t exec_ctl,
  input  chip8_pkg::addr_sel_t addr_sel,
  input  logic                 skip_taken,
  input  chip8_pkg::byte_t     v0,
  input  chip8_pkg::byte_t     vx_value,
  input  chip8_pkg::reg_idx_t  count,
  output chip8_pkg::addr_t     mem_addr
);
  import chip8_pkg::*;

  addr_t    pc;
  addr_t    i_reg;
  addr_t    pc_next2;
  addr_t    stack [`CHIP8_STACK_DEPTH];
  reg_idx_t sp;
  reg_idx_t sp_top;

  assign pc_next2 = pc + addr_t'(2);
  // sp points at the next free slot
  assign sp_top   = sp - 1'b1;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      pc    <= `CHIP8_RESET_PC;
      i_reg <= '0;
      sp    <= '0;
      for (int i = 0; i < `CHIP8_STACK_DEPTH; i++)
        stack[i] <= '0;
    end else begin
      case (exec_ctl.pc_op)
        PC_NEXT:    pc <= pc_next2;
        PC_SKIP:    pc <= skip_taken ? pc + addr_t'(4) : pc_next2;
        PC_JUMP:    pc <= exec_ctl.nnn;
        PC_JUMP_V0: pc <= exec_ctl.nnn + addr_t'(v0);
        PC_CALL: begin
          stack[sp] <= pc_next2;
          sp        <= sp + 1'b1;
          pc        <= exec_ctl.nnn;
        end
        PC_RET: begin
          sp <= sp_top;
          pc <= stack[sp_top];
        end
        default: pc <= pc;
      endcase
      if (exec_ctl.strobe) begin
        if (exec_ctl.i_load)
          i_reg <= exec_ctl.nnn;
        else if (exec_ctl.i_add)
          i_reg <= i_reg + addr_t'(vx_value);
      end
    end
  end

  always_comb begin
    case (addr_sel)
      ADDR_PC_PLUS1: mem_addr = pc + addr_t'(1);
      ADDR_I_COUNT:  mem_addr = i_reg + addr_t'(count);
      default:       mem_addr = pc;
    endcase
  end

endmodule

/* logic/chip8_control.sv */
// chip8 control fsm
// fetches the two opcode bytes, decodes them and sequences store bursts

`timescale 1ns/1ps

module chip8_control (
  input  logic                 clk,
  input  logic                 reset,
  input  chip8_pkg::byte_t     mem_rdata,
  input  logic                 last,
  output chip8_pkg::exec_ctl_t exec_ctl,
  output chip8_pkg::addr_sel_t addr_sel,
  output logic                 mem_read,
  output logic                 mem_write,
  output logic                 start,
  output chip8_pkg::reg_idx_t  limit,
  output logic                 advance
);
  import chip8_pkg::*;

  cpu_state_t state;
  opcode_t    opcode;
  exec_ctl_t  dec;
  logic       run;
  logic       is_store;

  // run holds off the first fetch until the cycle after reset release
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state <= FETCH_HI;
      run   <= 1'b0;
    end else begin
      run <= 1'b1;
      case (state)
        FETCH_HI: begin
          if (run)
            state <= FETCH_LO;
        end
        FETCH_LO:   state <= CAPTURE_LO;
        CAPTURE_LO: state <= EXECUTE;
        EXECUTE:    state <= is_store ? STORE_BURST : FETCH_HI;
        STORE_BURST: begin
          if (last)
            state <= FETCH_HI;
        end
        default:    state <= FETCH_HI;
      endcase
    end
  end

  // big endian, high byte sits at pc
  always_ff @(posedge clk) begin
    if (state == FETCH_LO)
      opcode[15:8] <= mem_rdata;
    if (state == CAPTURE_LO)
      opcode[7:0] <= mem_rdata;
  end

  always_comb begin
    dec.alu_op   = ALU_NONE;
    dec.pc_op    = PC_NEXT;
    dec.vx       = opcode[11:8];
    dec.vy       = opcode[7:4];
    dec.nn       = opcode[7:0];
    dec.nnn      = opcode[11:0];
    dec.i_load   = 1'b0;
    dec.i_add    = 1'b0;
    dec.bcd_mode = 1'b0;
    dec.strobe   = 1'b0;
    is_store     = 1'b0;
    case (opcode[15:12])
      4'h0: begin
        if (opcode == 16'h00EE)
          dec.pc_op = PC_RET;
      end
      4'h1: dec.pc_op = PC_JUMP;
      4'h2: dec.pc_op = PC_CALL;
      4'h3: begin
        dec.alu_op = ALU_SE_IMM;
        dec.pc_op  = PC_SKIP;
      end
      4'h4: begin
        dec.alu_op = ALU_SNE_IMM;
        dec.pc_op  = PC_SKIP;
      end
      4'h5: begin
        if (opcode[3:0] == 4'h0) begin
          dec.alu_op = ALU_SE_REG;
          dec.pc_op  = PC_SKIP;
        end
      end
      4'h6: dec.alu_op = ALU_LD_IMM;
      4'h7: dec.alu_op = ALU_ADD_IMM;
      4'h8: begin
        case (opcode[3:0])
          4'h0:    dec.alu_op = ALU_MOV;
          4'h1:    dec.alu_op = ALU_OR;
          4'h2:    dec.alu_op = ALU_AND;
          4'h3:    dec.alu_op = ALU_XOR;
          4'h4:    dec.alu_op = ALU_ADD;
          4'h5:    dec.alu_op = ALU_SUB;
          4'h6:    dec.alu_op = ALU_SHR;
          4'h7:    dec.alu_op = ALU_SUBN;
          4'hE:    dec.alu_op = ALU_SHL;
          default: dec.alu_op = ALU_NONE;
        endcase
      end
      4'h9: begin
        if (opcode[3:0] == 4'h0) begin
          dec.alu_op = ALU_SNE_REG;
          dec.pc_op  = PC_SKIP;
        end
      end
      4'hA: dec.i_load = 1'b1;
      4'hB: dec.pc_op = PC_JUMP_V0;
      4'hF: begin
        case (opcode[7:0])
          8'h1E: dec.i_add = 1'b1;
          8'h33: begin
            dec.bcd_mode = 1'b1;
            dec.pc_op    = PC_HOLD;
            is_store     = 1'b1;
          end
          8'h55: begin
            dec.pc_op = PC_HOLD;
            is_store  = 1'b1;
          end
          default: dec.pc_op = PC_NEXT;
        endcase
      end
      default: dec.pc_op = PC_NEXT;
    endcase
  end

  // pc only moves in execute, or on the final beat of a store burst
  always_comb begin
    exec_ctl        = dec;
    exec_ctl.strobe = (state == EXECUTE);
    if (state == STORE_BURST)
      exec_ctl.pc_op = last ? PC_NEXT : PC_HOLD;
    else if (state != EXECUTE)
      exec_ctl.pc_op = PC_HOLD;
  end

  always_comb begin
    case (state)
      FETCH_LO:    addr_sel = ADDR_PC_PLUS1;
      STORE_BURST: addr_sel = ADDR_I_COUNT;
      default:     addr_sel = ADDR_PC;
    endcase
  end

  assign mem_read  = run && (state == FETCH_HI || state == FETCH_LO);
  assign mem_write = (state == STORE_BURST);
  assign start     = (state == EXECUTE) && is_store;
  // bcd always writes three digits
  assign limit     = dec.bcd_mode ? reg_idx_t'(2) : dec.vx;
  assign advance   = (state == STORE_BURST);

endmodule

/* logic/chip8_cpu.sv */
// chip8 cpu top
// joins the control fsm, burst counter, register file and address unit

`timescale 1ns/1ps

module chip8_cpu (
  input  logic                clk,
  input  logic                reset,
  input  chip8_pkg::byte_t    mem_rdata,
  output chip8_pkg::mem_req_t mem_req
);
  import chip8_pkg::*;

  exec_ctl_t exec_ctl;
  addr_sel_t addr_sel;
  logic      mem_read;
  logic      mem_write;
  logic      start;
  logic      advance;
  logic      last;
  logic      skip_taken;
  reg_idx_t  limit;
  reg_idx_t  count;
  byte_t     v0;
  byte_t     vx_value;
  byte_t     wdata;
  addr_t     mem_addr;

  chip8_control u_control (
    .clk       (clk),
    .reset     (reset),
    .mem_rdata (mem_rdata),
    .last      (last),
    .exec_ctl  (exec_ctl),
    .addr_sel  (addr_sel),
    .mem_read  (mem_read),
    .mem_write (mem_write),
    .start     (start),
    .limit     (limit),
    .advance   (advance)
  );

  chip8_burst_counter u_burst_counter (
    .clk     (clk),
    .reset   (reset),
    .start   (start),
    .limit   (limit),
    .advance (advance),
    .count   (count),
    .last    (last)
  );

  chip8_regfile_alu u_regfile_alu (
    .clk        (clk),
    .reset      (reset),
    .exec_ctl   (exec_ctl),
    .count      (count),
    .skip_taken (skip_taken),
    .v0         (v0),
    .vx_value   (vx_value),
    .wdata      (wdata)
  );

  chip8_addr_unit u_addr_unit (
    .clk        (clk),
    .reset      (reset),
    .exec_ctl   (exec_ctl),
    .addr_sel   (addr_sel),
    .skip_taken (skip_taken),
    .v0         (v0),
    .vx_value   (vx_value),
    .count      (count),
    .mem_addr   (mem_addr)
  );

  assign mem_req = '{read: mem_read, write: mem_write, addr: mem_addr, wdata: wdata};

endmodule

/* dv/chip8_checker.sv */
// chip8 memory bus checker
// protocol assertions on the cpu memory request, bound into the top level

`timescale 1ns/1ps

module chip8_checker (
  input logic                clk,
  input logic                reset,
  input chip8_pkg::mem_req_t mem_req
);
  import chip8_pkg::*;

  logic        rd;
  logic        wr;
  addr_t       addr;
  int unsigned fail_count = 0;

  assign rd   = mem_req.read;
  assign wr   = mem_req.write;
  assign addr = mem_req.addr;

  strobes_exclusive: assert property (@(posedge clk) disable iff (reset) !(rd && wr))
    else begin
      fail_count++;
      $error("read and write strobes high in the same cycle");
    end

  quiet_in_reset: assert property (@(posedge clk) reset |-> (!rd && !wr))
    else begin
      fail_count++;
      $error("memory strobe active during reset");
    end

  // high byte read at pc, low byte at pc plus one on the next cycle
  fetch_pair: assert property (@(posedge clk) disable iff (reset)
    $rose(rd) |=> (rd && (addr == addr_t'($past(addr) + 1))))
    else begin
      fail_count++;
      $error("opcode high byte read not followed by a read at pc plus one");
    end

  // a read inside a burst would be followed by a further write
  no_read_in_burst: assert property (@(posedge clk) disable iff (reset) rd |=> !wr)
    else begin
      fail_count++;
      $error("read strobe inside a write burst");
    end

endmodule

bind chip8_cpu chip8_checker u_checker (
  .clk     (clk),
  .reset   (reset),
  .mem_req (mem_req)
);

/* dv/chip8_tb.sv */
// chip8 cpu testbench
// random program in a byte memory, checked against an instruction-level model

`timescale 1ns/1ps

`include "chip8_consts.svh"

module chip8_tb;
  import chip8_pkg::*;

  localparam int NUM_INSTR        = 400;
  localparam int MAX_INSTR_CYCLES = 20;
  localparam int TIMEOUT_CYCLES   = NUM_INSTR * MAX_INSTR_CYCLES + 100;
  localparam int MEM_SIZE         = 1 << `CHIP8_ADDR_W;

  logic     clk;
  logic     reset;
  byte_t    mem_rdata;
  mem_req_t mem_req;

  byte_t    mem [MEM_SIZE];
  integer   seed;
  int       cycle_count = 0;
  mem_req_t req;

  // reference model state
  addr_t    m_pc;
  addr_t    m_i;
  byte_t    m_v [`CHIP8_NUM_REGS];
  addr_t    m_stack [`CHIP8_STACK_DEPTH];
  reg_idx_t m_sp;
  addr_t    exp_addr [$];
  byte_t    exp_data [$];

  chip8_cpu UUT (
    .clk       (clk),
    .reset     (reset),
    .mem_rdata (mem_rdata),
    .mem_req   (mem_req)
  );

  always #20 clk = ~clk;

  // read data is valid in the cycle after the strobe
  always @(posedge clk) begin
    if (mem_req.read)
      mem_rdata <= mem[mem_req.addr];
  end

  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count > TIMEOUT_CYCLES)
      abort_run($sformatf("timeout: run went past %0d cycles", TIMEOUT_CYCLES));
    if (UUT.u_checker.fail_count != 0)
      abort_run("a bus protocol assertion failed");
  end

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Test failed");
    $fatal(1, "simulation stopped on first error");
  endtask

  task automatic check_addr(input string name, input addr_t got, input addr_t exp);
    if (got !== exp)
      abort_run($sformatf("CHECK FAILED %s: got 0x%h, expected 0x%h", name, got, exp));
  endtask

  task automatic check_byte(input string name, input byte_t got, input byte_t exp);
    if (got !== exp)
      abort_run($sformatf("CHECK FAILED %s: got 0x%h, expected 0x%h", name, got, exp));
  endtask

  task automatic sample_bus();
    @(posedge clk);
    req = mem_req;
    if (req.read && req.write)
      abort_run("read and write strobes were high in the same cycle");
  endtask

  function automatic opcode_t random_opcode();
    int         kind;
    int         alu_sel;
    logic [3:0] alu_n;
    addr_t      nnn;
    reg_idx_t   x;
    reg_idx_t   y;
    byte_t      nn;
    opcode_t    op;
    kind    = $unsigned($random(seed)) % 20;
    alu_sel = $unsigned($random(seed)) % 10;
    nnn     = addr_t'($random(seed));
    x       = reg_idx_t'($random(seed));
    y       = reg_idx_t'($random(seed));
    nn      = byte_t'($random(seed));
    // small immediates give the skips a fair chance of matching
    if (nn[7])
      nn = nn & 8'h03;
    case (alu_sel)
      8:       alu_n = 4'hE;
      9:       alu_n = 4'hB;
      default: alu_n = 4'(alu_sel);
    endcase
    case (kind)
      0:              op = {4'h1, nnn & 12'hFFE};
      1:              op = {4'hB, nnn};
      2:              op = {4'h2, nnn & 12'hFFE};
      3:              op = 16'h00EE;
      4:              op = {4'h3, x, nn};
      5:              op = {4'h4, x, nn};
      6:              op = {4'h5, x, y, 4'h0};
      7:              op = {4'h9, x, y, 4'h0};
      8:              op = {4'h6, x, nn};
      9:              op = {4'h7, x, nn};
      10, 11, 12, 13: op = {4'h8, x, y, alu_n};
      14:             op = {4'hA, nnn};
      15:             op = {4'hF, x, 8'h1E};
      16:             op = {4'hF, x, 8'h33};
      17:             op = {4'hF, x, 8'h55};
      18:             op = {4'hD, x, y, nn[3:0]};
      default:        op = {4'h0, nnn};
    endcase
    return op;
  endfunction

  task automatic fill_memory();
    opcode_t word;
    for (int a = 0; a < MEM_SIZE; a += 2) begin
      word       = random_opcode();
      mem[a]     = word[15:8];
      mem[a + 1] = word[7:0];
    end
  endtask

  task automatic reset_model();
    m_pc = `CHIP8_RESET_PC;
    m_i  = '0;
    m_sp = '0;
    for (int r = 0; r < `CHIP8_NUM_REGS; r++)
      m_v[r] = '0;
    for (int s = 0; s < `CHIP8_STACK_DEPTH; s++)
      m_stack[s] = '0;
  endtask

  task automatic expect_write(input addr_t a, input byte_t d);
    exp_addr.push_back(a);
    exp_data.push_back(d);
  endtask

  // decimal digits by repeated subtraction
  task automatic split_decimal(input byte_t value, output byte_t hundreds,
                               output byte_t tens, output byte_t units);
    hundreds = '0;
    tens     = '0;
    units    = value;
    while (units >= 8'd100) begin
      units    = units - 8'd100;
      hundreds = hundreds + 8'd1;
    end
    while (units >= 8'd10) begin
      units = units - 8'd10;
      tens  = tens + 8'd1;
    end
  endtask

  task automatic model_alu(input reg_idx_t x, input reg_idx_t y, input logic [3:0] n);
    byte_t      vx;
    byte_t      vy;
    logic [8:0] total;
    vx    = m_v[x];
    vy    = m_v[y];
    total = {1'b0, vx} + {1'b0, vy};
    // flag written last, so VF ends up holding it when X is F
    case (n)
      4'h0: m_v[x] = vy;
      4'h1: m_v[x] = vx | vy;
      4'h2: m_v[x] = vx & vy;
      4'h3: m_v[x] = vx ^ vy;
      4'h4: begin
        m_v[x]                = total[7:0];
        m_v[`CHIP8_FLAG_REG] = {7'd0, total[8]};
      end
      4'h5: begin
        m_v[x]                = vx - vy;
        m_v[`CHIP8_FLAG_REG] = (vx >= vy) ? 8'd1 : 8'd0;
      end
      4'h6: begin
        m_v[x]                = vx >> 1;
        m_v[`CHIP8_FLAG_REG] = {7'd0, vx[0]};
      end
      4'h7: begin
        m_v[x]                = vy - vx;
        m_v[`CHIP8_FLAG_REG] = (vy > vx) ? 8'd1 : 8'd0;
      end
      4'hE: begin
        m_v[x]                = vx << 1;
        m_v[`CHIP8_FLAG_REG] = {7'd0, vx[7]};
      end
      default: ;
    endcase
  endtask

  // runs one instruction on the model, queues its writes, returns the fetch gap
  task automatic model_execute(input opcode_t op, output int gap);
    reg_idx_t x;
    reg_idx_t y;
    byte_t    nn;
    addr_t    nnn;
    addr_t    next_pc;
    logic     take_skip;
    byte_t    digit_h;
    byte_t    digit_t;
    byte_t    digit_u;
    x         = op[11:8];
    y         = op[7:4];
    nn        = op[7:0];
    nnn       = op[11:0];
    next_pc   = m_pc + addr_t'(2);
    take_skip = 1'b0;
    case (op[15:12])
      4'h0: begin
        if (op == 16'h00EE) begin
          m_sp    = m_sp - 1'b1;
          next_pc = m_stack[m_sp];
        end
      end
      4'h1: next_pc = nnn;
      4'h2: begin
        m_stack[m_sp] = m_pc + addr_t'(2);
        m_sp          = m_sp + 1'b1;
        next_pc       = nnn;
      end
      4'h3: take_skip = (m_v[x] == nn);
      4'h4: take_skip = (m_v[x] != nn);
      4'h5: take_skip = (op[3:0] == 4'h0) && (m_v[x] == m_v[y]);
      4'h6: m_v[x] = nn;
      4'h7: m_v[x] = m_v[x] + nn;
      4'h8: model_alu(x, y, op[3:0]);
      4'h9: take_skip = (op[3:0] == 4'h0) && (m_v[x] != m_v[y]);
      4'hA: m_i = nnn;
      4'hB: next_pc = nnn + addr_t'(m_v[0]);
      4'hF: begin
        case (nn)
          8'h1E: m_i = m_i + addr_t'(m_v[x]);
          8'h33: begin
            split_decimal(m_v[x], digit_h, digit_t, digit_u);
            expect_write(m_i, digit_h);
            expect_write(addr_t'(m_i + 1), digit_t);
            expect_write(addr_t'(m_i + 2), digit_u);
          end
          8'h55: begin
            for (int k = 0; k <= int'(x); k++)
              expect_write(addr_t'(m_i + k), m_v[k]);
          end
          default: ;
        endcase
      end
      default: ;
    endcase
    if (take_skip)
      next_pc = m_pc + addr_t'(4);
    m_pc = next_pc;
    gap  = 4 + exp_addr.size();
  endtask

  initial begin : main_seq
    opcode_t op;
    addr_t   fetch_addr;
    int      gap;
    clk       = 1'b0;
    reset     = 1'b1;
    mem_rdata = '0;
    seed      = 32'hbe318754;
    fill_memory();
    reset_model();
    repeat (5) @(posedge clk);
    reset <= 1'b0;

    // the release cycle stays idle and the fetch starts one cycle later
    sample_bus();
    if (req.read || req.write)
      abort_run("memory strobe in the cycle reset was released");
    sample_bus();
    if (!req.read)
      abort_run("no instruction fetch in the first cycle after reset release");

    for (int n = 0; n < NUM_INSTR; n++) begin
      fetch_addr = m_pc;
      check_addr("mem_req.addr (opcode high byte)", req.addr, fetch_addr);
      sample_bus();
      if (!req.read)
        abort_run("missing fetch: no read of the opcode low byte");
      check_addr("mem_req.addr (opcode low byte)", req.addr, addr_t'(fetch_addr + 1));
      op = {mem[fetch_addr], mem[addr_t'(fetch_addr + 1)]};
      model_execute(op, gap);

      // capture and execute cycles carry no strobe
      repeat (2) begin
        sample_bus();
        if (req.read || req.write)
          abort_run($sformatf("unexpected strobe while executing opcode %h", op));
      end

      // one write per cycle for the whole burst
      repeat (gap - 4) begin
        sample_bus();
        if (!req.write)
          abort_run($sformatf("missing write in the store burst of opcode %h", op));
        check_addr("mem_req.addr (write)", req.addr, exp_addr[0]);
        check_byte("mem_req.wdata", req.wdata, exp_data[0]);
        mem[req.addr] = req.wdata;
        void'(exp_addr.pop_front());
        void'(exp_data.pop_front());
      end

      sample_bus();
      if (!req.read)
        abort_run($sformatf("missing fetch %0d cycles after opcode %h", gap, op));
    end

    if (UUT.u_checker.fail_count == 0) begin
      $display("Test completed successfully");
      $finish;
    end else begin
      abort_run("a bus protocol assertion failed");
    end
  end

endmodule

/* sim.f */
+incdir+include
logic/chip8_pkg.sv
logic/chip8_burst_counter.sv
logic/chip8_regfile_alu.sv
logic/chip8_addr_unit.sv
logic/chip8_control.sv
logic/chip8_cpu.sv
dv/chip8_checker.sv
dv/chip8_tb.sv
